// File: riscv_lsu_memstage.f
logic/riscv_lsu_pkg.sv
logic/riscv_lsu.sv
logic/riscv_lsu_store_align.sv
logic/riscv_lsu_dmem.sv
logic/riscv_lsu_load_ext.sv
logic/riscv_lsu_memstage.sv
tests/riscv_lsu_memstage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= riscv_lsu_memstage_tb
FILELIST  ?= riscv_lsu_memstage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/riscv_lsu_memstage_tb.sv
module riscv_lsu_memstage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import riscv_lsu_pkg::*;

  localparam int max_cycles = 2000; // about four times the test sequence
  localparam int pool_base  = 64;   // first double word of the test region

  logic            clk;
  logic            rst;
  logic            stall;
  logic            goto_trap;
  logic            return_trap;
  lsu_req_t        req;
  mem_cmd_t        cmd;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] sc_rdvalue;

  // expected outputs for the request on the inputs
  logic            exp_rd;
  logic            exp_wr;
  logic [xlen-1:0] exp_addr;
  logic [7:0]      exp_be;
  logic [xlen-1:0] exp_wdata;  // enabled lanes only
  logic [xlen-1:0] exp_sc_rd;
  logic [xlen-1:0] exp_load;
  logic [xlen-1:0] load_exp_q; // read in flight
  logic            read_seen;

  logic [7:0]      model_mem [dmem_words*8];
  logic [xlen-1:0] res_addr;
  logic            res_valid;
  logic            cur_goto;
  logic            cur_ret;
  logic            cur_stall;
  integer          seed;
  int              err_count;
  int              errs_at_start;
  int              tests_passed;
  int              tests_failed;
  int              cycle_count;

  riscv_lsu_memstage i_dut (
    .i_riscv_lsu_clk         (clk),
    .i_riscv_lsu_rst         (rst),
    .i_riscv_lsu_globstall   (stall),
    .i_riscv_lsu_req         (req),
    .i_riscv_lsu_goto_trap   (goto_trap),
    .i_riscv_lsu_return_trap (return_trap),
    .o_riscv_lsu_mem_cmd     (cmd),
    .o_riscv_lsu_load_data   (load_data),
    .o_riscv_lsu_sc_rdvalue  (sc_rdvalue)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_value(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
    $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    err_count++;
  endtask

  task automatic report_event(input string msg);
    $display("%s at %0t", msg, $time);
    err_count++;
  endtask

  // byte lanes touched by an access of this size at this offset
  function automatic logic [7:0] lane_enables(input logic [2:0] size, input logic [2:0] off);
    logic [7:0] m;
    m = '0;
    for (int i = 0; i < (1 << size[1:0]); i++)
    begin
      m[off + i] = 1'b1;
    end
    return m;
  endfunction

  // low bytes of the store data placed at the addressed lanes
  function automatic logic [xlen-1:0] placed_data(input logic [2:0] size,
                                                  input logic [2:0] off,
                                                  input logic [xlen-1:0] data);
    logic [xlen-1:0] v;
    v = '0;
    for (int i = 0; i < (1 << size[1:0]); i++)
    begin
      v[8*(int'(off) + i) +: 8] = data[8*i +: 8];
    end
    return v;
  endfunction

  function automatic logic [xlen-1:0] enabled_lanes(input logic [xlen-1:0] v,
                                                    input logic [7:0] be);
    logic [xlen-1:0] m;
    m = '0;
    for (int b = 0; b < 8; b++)
    begin
      if (be[b])
      begin
        m[8*b +: 8] = v[8*b +: 8];
      end
    end
    return m;
  endfunction

  function automatic logic [xlen-1:0] expected_load(input logic [xlen-1:0] addr,
                                                    input logic [2:0] size);
    int              nbytes;
    logic [xlen-1:0] v;
    nbytes = 1 << size[1:0];
    v = '0;
    for (int i = 0; i < nbytes; i++)
    begin
      v[8*i +: 8] = model_mem[int'(addr[11:0]) + i]; // little endian
    end
    if (!size[2] && nbytes < 8 && v[8*nbytes-1])
    begin
      v = v | ({xlen{1'b1}} << (8*nbytes));
    end
    return v;
  endfunction

  task automatic model_write(input logic [xlen-1:0] addr, input logic [2:0] size,
                             input logic [xlen-1:0] data);
    for (int i = 0; i < (1 << size[1:0]); i++)
    begin
      model_mem[int'(addr[11:0]) + i] = data[8*i +: 8];
    end
  endtask

  // random naturally aligned address inside a 16 double word region
  function automatic logic [xlen-1:0] pool_addr(input logic [2:0] size);
    logic [xlen-1:0] a;
    a = 64'((pool_base + ($random(seed) & 15)) * 8);
    a[2:0] = 3'($random(seed)) & ~3'((1 << size[1:0]) - 1);
    return a;
  endfunction

  function automatic logic [xlen-1:0] rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  // one request for one cycle, with models and expectations updated alongside
  task automatic send(input logic [4:0] flags, input logic [2:0] size,
                      input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
    lsu_req_t r;
    logic     trap;
    logic     sc_ok;
    logic     is_rd;
    logic     is_wr;
    r = '0;
    {r.memread, r.memwrite, r.lr, r.sc, r.amo} = flags;
    r.size       = size;
    r.store_data = data;
    r.alu_result = (flags[4] || flags[3]) ? addr : ~addr; // decoy on the unused source
    r.rs1        = (flags[4] || flags[3]) ? ~addr : addr;
    trap  = cur_goto || cur_ret;
    sc_ok = (flags == 5'b00010) && res_valid && (res_addr == addr) && !trap;
    is_rd = $onehot(flags) && (flags[4] || flags[2] || flags[0]) && !trap;
    is_wr = ((flags == 5'b01000) && !trap) || sc_ok;
    if (is_wr && !cur_stall)
    begin
      model_write(addr, size, data);
    end
    if (!cur_stall && flags == 5'b00100)
    begin
      res_addr  = addr;
      res_valid = 1'b1;
    end
    else if (!cur_stall && flags == 5'b00010)
    begin
      res_valid = 1'b0;
    end
    @(posedge clk);
    req         <= r;
    goto_trap   <= cur_goto;
    return_trap <= cur_ret;
    stall       <= cur_stall;
    exp_rd      <= is_rd;
    exp_wr      <= is_wr;
    exp_addr    <= $onehot(flags) ? addr : '0;
    exp_be      <= lane_enables(size, addr[2:0]);
    exp_wdata   <= placed_data(size, addr[2:0], data);
    exp_sc_rd   <= (flags == 5'b00010) ? 64'(!sc_ok) : '0;
    if (is_rd)
    begin
      exp_load <= expected_load(addr, size);
    end
    if (is_rd && !cur_stall)
    begin
      read_seen <= 1'b1;
    end
  endtask

  task automatic finish_test(input string name);
    send('0, size_b, '0, '0);
    send('0, size_b, '0, '0);
    @(posedge clk);
    #1; // last checks have reported by now
    if (err_count == errs_at_start)
    begin
      tests_passed++;
      $display("test %-12s passed", name);
    end
    else
    begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", name, err_count - errs_at_start);
    end
    errs_at_start = err_count;
  endtask

  task automatic run_reset_idle();
    logic [4:0] bad [4];
    bad = '{5'b11000, 5'b00110, 5'b10001, 5'b11111};
    for (int i = 0; i < 4; i++)
    begin
      send(bad[i], size_d, pool_addr(size_d), rand_data());
    end
    finish_test("reset_idle");
  endtask

  task automatic run_store_load();
    logic [xlen-1:0] a;
    logic [2:0]      load_sizes [7];
    load_sizes = '{size_b, size_h, size_w, size_d, size_bu, size_hu, size_wu};
    for (int w = 0; w < 16; w++)
    begin
      send(kind_normal_write, size_d, 64'((pool_base + w) * 8), rand_data());
    end
    for (int i = 0; i < 200; i++)
    begin
      a = pool_addr(3'(i % 4)); // b, h, w, d codes
      send(kind_normal_write, 3'(i % 4), a, rand_data());
      a = pool_addr(load_sizes[i % 7]);
      send(kind_normal_read, load_sizes[i % 7], a, rand_data());
    end
    for (int w = 0; w < 16; w++)
    begin
      send(kind_normal_read, size_d, 64'((pool_base + w) * 8), '0);
    end
    send(kind_amo, size_d, pool_addr(size_d), rand_data()); // read half only
    finish_test("store_load");
  endtask

  task automatic run_lr_sc();
    logic [xlen-1:0] a;
    logic [2:0]      sz;
    for (int i = 0; i < 4; i++)
    begin
      sz = i[0] ? size_w : size_d;
      a  = pool_addr(size_d);
      send(kind_lr, sz, a, '0);
      send(kind_sc, sz, a, rand_data());
      send(kind_normal_read, size_d, a, '0);
      send(kind_sc, sz, a, rand_data()); // reservation already used
      send(kind_normal_read, size_d, a, '0);
    end
    finish_test("lr_sc");
  endtask

  task automatic run_sc_mismatch();
    logic [xlen-1:0] a;
    for (int i = 0; i < 4; i++)
    begin
      a = pool_addr(size_d);
      send(kind_lr, size_d, a, '0);
      send(kind_sc, size_d, a ^ 64'h8, rand_data());
      send(kind_normal_read, size_d, a ^ 64'h8, '0);
      send(kind_sc, size_d, a, rand_data()); // no reservation left
      send(kind_normal_read, size_d, a, '0);
    end
    finish_test("sc_mismatch");
  endtask

  task automatic run_trap();
    logic [xlen-1:0] a;
    for (int t = 0; t < 2; t++)
    begin
      a = pool_addr(size_d);
      cur_goto = (t == 0);
      cur_ret  = (t == 1);
      send(kind_normal_read, size_w, a ^ 64'h8, '0);
      send(kind_normal_write, size_d, a ^ 64'h8, rand_data());
      cur_goto = 1'b0;
      cur_ret  = 1'b0;
      send(kind_lr, size_d, a, '0);
      cur_goto = (t == 0);
      cur_ret  = (t == 1);
      send(kind_sc, size_d, a, rand_data());
      cur_goto = 1'b0;
      cur_ret  = 1'b0;
      send(kind_normal_read, size_d, a, '0);
      send(kind_normal_read, size_d, a ^ 64'h8, '0);
    end
    finish_test("trap");
  endtask

  task automatic run_stall();
    logic [xlen-1:0] a;
    a = pool_addr(size_d);
    send(kind_normal_read, size_d, a, '0);
    cur_stall = 1'b1;
    send(kind_lr, size_d, a ^ 64'h8, '0);
    send(kind_normal_write, size_d, a, rand_data());
    send(kind_normal_read, size_h, a, '0);
    cur_stall = 1'b0;
    send(kind_sc, size_d, a ^ 64'h8, rand_data());
    send(kind_normal_read, size_d, a, '0);
    send(kind_normal_read, size_d, a ^ 64'h8, '0);
    finish_test("stall");
  endtask

  always @(posedge clk)
  begin
    if (exp_rd && !stall)
    begin
      load_exp_q <= exp_load;
    end
  end

  a_rd_en: assert property (@(posedge clk) disable iff (rst) cmd.rd_en == exp_rd)
    else report_value("o_riscv_lsu_mem_cmd.rd_en", $sampled(cmd.rd_en), $sampled(exp_rd));
  a_wr_en: assert property (@(posedge clk) disable iff (rst) cmd.wr_en == exp_wr)
    else report_value("o_riscv_lsu_mem_cmd.wr_en", $sampled(cmd.wr_en), $sampled(exp_wr));
  a_addr: assert property (@(posedge clk) disable iff (rst) cmd.addr == exp_addr)
    else report_value("o_riscv_lsu_mem_cmd.addr", $sampled(cmd.addr), $sampled(exp_addr));
  a_byte_en: assert property (@(posedge clk) disable iff (rst)
    exp_wr |-> cmd.byte_en == exp_be)
    else report_value("o_riscv_lsu_mem_cmd.byte_en", $sampled(cmd.byte_en), $sampled(exp_be));
  a_wdata: assert property (@(posedge clk) disable iff (rst)
    exp_wr |-> enabled_lanes(cmd.wdata, exp_be) == exp_wdata)
    else report_value("o_riscv_lsu_mem_cmd.wdata",
                      enabled_lanes($sampled(cmd.wdata), $sampled(exp_be)),
                      $sampled(exp_wdata));
  a_sc_rd: assert property (@(posedge clk) disable iff (rst) sc_rdvalue == exp_sc_rd)
    else report_value("o_riscv_lsu_sc_rdvalue", $sampled(sc_rdvalue), $sampled(exp_sc_rd));
  a_exclusive: assert property (@(posedge clk) disable iff (rst) !(cmd.rd_en && cmd.wr_en))
    else report_event("read and write enables were high in the same cycle");
  a_load: assert property (@(posedge clk) disable iff (rst)
    (exp_rd && !stall) |=> load_data == load_exp_q)
    else report_value("o_riscv_lsu_load_data", $sampled(load_data), $sampled(load_exp_q));
  a_load_hold: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(load_data))
    else report_event("load data changed while the stage was stalled");
  a_load_zero: assert property (@(posedge clk) disable iff (rst) !read_seen |-> load_data == '0)
    else report_value("o_riscv_lsu_load_data", $sampled(load_data), '0);

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles)
    begin
      $display("timeout, the tests did not finish within %0d cycles", max_cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial
  begin
    seed = 32'hb59c;
    rst = 1'b1;
    stall = 1'b0;
    goto_trap = 1'b0;
    return_trap = 1'b0;
    req = '0;
    {exp_rd, exp_wr, exp_addr, exp_be, exp_wdata, exp_sc_rd, exp_load} = '0;
    read_seen = 1'b0;
    res_addr = '0;
    res_valid = 1'b0;
    {cur_goto, cur_ret, cur_stall} = '0;
    {err_count, errs_at_start, tests_passed, tests_failed, cycle_count} = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    run_reset_idle();
    run_store_load();
    run_lr_sc();
    run_sc_mismatch();
    run_trap();
    run_stall();
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: logic/riscv_lsu_memstage.sv
module riscv_lsu_memstage (
  input  logic                           i_riscv_lsu_clk,
  input  logic                           i_riscv_lsu_rst,
  input  logic                           i_riscv_lsu_globstall,
  input  riscv_lsu_pkg::lsu_req_t        i_riscv_lsu_req,
  input  logic                           i_riscv_lsu_goto_trap,
  input  logic                           i_riscv_lsu_return_trap,
  output riscv_lsu_pkg::mem_cmd_t        o_riscv_lsu_mem_cmd,
  output logic [riscv_lsu_pkg::xlen-1:0] o_riscv_lsu_load_data,
  output logic [riscv_lsu_pkg::xlen-1:0] o_riscv_lsu_sc_rdvalue
);

  import riscv_lsu_pkg::*;

  logic            rd_en;
  logic            wr_en;
  logic [xlen-1:0] mem_address;
  logic [7:0]      byte_en;
  logic [xlen-1:0] wdata;
  logic [xlen-1:0] rdata;
  mem_cmd_t        mem_cmd;

  // control half of the command
  riscv_lsu u_lsu (
    .i_riscv_lsu_clk         (i_riscv_lsu_clk),
    .i_riscv_lsu_rst         (i_riscv_lsu_rst),
    .i_riscv_lsu_globstall   (i_riscv_lsu_globstall),
    .i_riscv_lsu_req         (i_riscv_lsu_req),
    .i_riscv_lsu_goto_trap   (i_riscv_lsu_goto_trap),
    .i_riscv_lsu_return_trap (i_riscv_lsu_return_trap),
    .o_riscv_lsu_rd_en       (rd_en),
    .o_riscv_lsu_wr_en       (wr_en),
    .o_riscv_lsu_mem_address (mem_address),
    .o_riscv_lsu_sc_rdvalue  (o_riscv_lsu_sc_rdvalue)
  );

  // data half of the command
  riscv_lsu_store_align u_store_align (
    .i_riscv_lsu_size       (i_riscv_lsu_req.size),
    .i_riscv_lsu_offset     (mem_address[2:0]),
    .i_riscv_lsu_store_data (i_riscv_lsu_req.store_data),
    .o_riscv_lsu_byte_en    (byte_en),
    .o_riscv_lsu_wdata      (wdata)
  );

  always_comb
  begin
    mem_cmd.rd_en   = rd_en;
    mem_cmd.wr_en   = wr_en;
    mem_cmd.addr    = mem_address;
    mem_cmd.byte_en = byte_en;
    mem_cmd.wdata   = wdata;
  end

  assign o_riscv_lsu_mem_cmd = mem_cmd; // seen by hazard logic

  riscv_lsu_dmem u_dmem (
    .i_riscv_lsu_clk       (i_riscv_lsu_clk),
    .i_riscv_lsu_rst       (i_riscv_lsu_rst),
    .i_riscv_lsu_globstall (i_riscv_lsu_globstall),
    .i_riscv_lsu_cmd       (mem_cmd),
    .o_riscv_lsu_rdata     (rdata)
  );

  riscv_lsu_load_ext u_load_ext (
    .i_riscv_lsu_clk       (i_riscv_lsu_clk),
    .i_riscv_lsu_rst       (i_riscv_lsu_rst),
    .i_riscv_lsu_globstall (i_riscv_lsu_globstall),
    .i_riscv_lsu_size      (i_riscv_lsu_req.size),
    .i_riscv_lsu_offset    (mem_address[2:0]),
    .i_riscv_lsu_rdata     (rdata),
    .o_riscv_lsu_load_data (o_riscv_lsu_load_data)
  );

endmodule

// File: logic/riscv_lsu_load_ext.sv
module riscv_lsu_load_ext (
  input  logic                           i_riscv_lsu_clk,
  input  logic                           i_riscv_lsu_rst,
  input  logic                           i_riscv_lsu_globstall,
  input  logic [2:0]                     i_riscv_lsu_size,
  input  logic [2:0]                     i_riscv_lsu_offset,
  input  logic [riscv_lsu_pkg::xlen-1:0] i_riscv_lsu_rdata,
  output logic [riscv_lsu_pkg::xlen-1:0] o_riscv_lsu_load_data
);

  import riscv_lsu_pkg::*;

  logic [2:0]      size_q;
  logic [2:0]      offset_q;
  logic [xlen-1:0] shifted;
  logic            is_unsigned;

  // captured with the read so they line up with the registered word
  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
    begin
      size_q   <= size_b;
      offset_q <= 3'b000;
    end
    else if (!i_riscv_lsu_globstall)
    begin
      size_q   <= i_riscv_lsu_size;
      offset_q <= i_riscv_lsu_offset;
    end
  end

  assign shifted     = i_riscv_lsu_rdata >> {offset_q, 3'b000}; // lane down to bit 0
  assign is_unsigned = (size_q == size_bu) || (size_q == size_hu) || (size_q == size_wu);

  always_comb
  begin
    case (size_q)
      size_b, size_bu:
        o_riscv_lsu_load_data = {{(xlen-8){!is_unsigned && shifted[7]}}, shifted[7:0]};
      size_h, size_hu:
        o_riscv_lsu_load_data = {{(xlen-16){!is_unsigned && shifted[15]}}, shifted[15:0]};
      size_w, size_wu:
        o_riscv_lsu_load_data = {{(xlen-32){!is_unsigned && shifted[31]}}, shifted[31:0]};
      default:
        o_riscv_lsu_load_data = shifted; // double word
    endcase
  end

endmodule

// File: logic/riscv_lsu_dmem.sv
module riscv_lsu_dmem (
  input  logic                           i_riscv_lsu_clk,
  input  logic                           i_riscv_lsu_rst,
  input  logic                           i_riscv_lsu_globstall,
  input  riscv_lsu_pkg::mem_cmd_t        i_riscv_lsu_cmd,
  output logic [riscv_lsu_pkg::xlen-1:0] o_riscv_lsu_rdata
);

  import riscv_lsu_pkg::*;

  logic [xlen-1:0]               mem [dmem_words];
  logic [$clog2(dmem_words)-1:0] idx;
  logic [xlen-1:0]               rdata_q;

  // double word index, offset bits dropped
  assign idx = i_riscv_lsu_cmd.addr[$clog2(dmem_words)+2:3];

  // byte-enabled write, blocked by stall
  always_ff @(posedge i_riscv_lsu_clk)
  begin
    if (i_riscv_lsu_cmd.wr_en && !i_riscv_lsu_globstall)
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (i_riscv_lsu_cmd.byte_en[b])
        begin
          mem[idx][b*8 +: 8] <= i_riscv_lsu_cmd.wdata[b*8 +: 8];
        end
      end
    end
  end

  // registered read port
  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
    begin
      rdata_q <= '0;
    end
    else if (i_riscv_lsu_cmd.rd_en && !i_riscv_lsu_globstall)
    begin
      rdata_q <= mem[idx];
    end
  end

  assign o_riscv_lsu_rdata = rdata_q;

  // upper address bits must not alias onto the array
  a_index_in_range: assert property (
    @(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
    (i_riscv_lsu_cmd.rd_en || i_riscv_lsu_cmd.wr_en)
      |-> (i_riscv_lsu_cmd.addr[xlen-1:3] < dmem_words))
    else $error("dmem address %h out of range", i_riscv_lsu_cmd.addr);

endmodule

// File: logic/riscv_lsu_store_align.sv
module riscv_lsu_store_align (
  input  logic [2:0]                     i_riscv_lsu_size,
  input  logic [2:0]                     i_riscv_lsu_offset,
  input  logic [riscv_lsu_pkg::xlen-1:0] i_riscv_lsu_store_data,
  output logic [7:0]                     o_riscv_lsu_byte_en,
  output logic [riscv_lsu_pkg::xlen-1:0] o_riscv_lsu_wdata
);

  import riscv_lsu_pkg::*;

  logic [7:0] size_mask; // enables before the lane shift

  always_comb
  begin
    case (i_riscv_lsu_size)
      size_b:  size_mask = 8'h01;
      size_h:  size_mask = 8'h03;
      size_w:  size_mask = 8'h0f;
      size_d:  size_mask = 8'hff;
      default: size_mask = 8'h00; // unsigned codes are load only
    endcase
  end

  // move the low bytes up to the addressed lane
  assign o_riscv_lsu_byte_en = size_mask << i_riscv_lsu_offset;
  assign o_riscv_lsu_wdata   = i_riscv_lsu_store_data << {i_riscv_lsu_offset, 3'b000};

  // misaligned accesses would lose bytes off the top lane
  always_comb
  begin
    if (i_riscv_lsu_size == size_h)
    begin
      a_half_align: assert final (i_riscv_lsu_offset[0] == 1'b0)
        else $error("half access at odd offset %0d", i_riscv_lsu_offset);
    end
    else if (i_riscv_lsu_size == size_w)
    begin
      a_word_align: assert final (i_riscv_lsu_offset[1:0] == 2'b00)
        else $error("word access at offset %0d", i_riscv_lsu_offset);
    end
  end

endmodule

// File: logic/riscv_lsu.sv
module riscv_lsu (
  input  logic                           i_riscv_lsu_clk,
  input  logic                           i_riscv_lsu_rst,
  input  logic                           i_riscv_lsu_globstall,
  input  riscv_lsu_pkg::lsu_req_t        i_riscv_lsu_req,
  input  logic                           i_riscv_lsu_goto_trap,
  input  logic                           i_riscv_lsu_return_trap,
  output logic                           o_riscv_lsu_rd_en,
  output logic                           o_riscv_lsu_wr_en,
  output logic [riscv_lsu_pkg::xlen-1:0] o_riscv_lsu_mem_address,
  output logic [riscv_lsu_pkg::xlen-1:0] o_riscv_lsu_sc_rdvalue
);

  import riscv_lsu_pkg::*;

  lsu_kind_t       kind;
  logic            trap_active;
  logic [xlen-1:0] reserv_addr;
  logic            reserv_valid;
  logic            sc_success;

  // flags packed in the same order as the enum bits
  assign kind = lsu_kind_t'({i_riscv_lsu_req.memread,
                             i_riscv_lsu_req.memwrite,
                             i_riscv_lsu_req.lr,
                             i_riscv_lsu_req.sc,
                             i_riscv_lsu_req.amo});

  assign trap_active = i_riscv_lsu_goto_trap || i_riscv_lsu_return_trap;

  // sc only wins on a live reservation of the exact rs1 address
  assign sc_success = (kind == kind_sc) &&
                      reserv_valid &&
                      (i_riscv_lsu_req.rs1 == reserv_addr) &&
                      !trap_active;

  // reservation register
  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
    begin
      reserv_addr  <= '0;
      reserv_valid <= 1'b0;
    end
    else if (!i_riscv_lsu_globstall)
    begin
      if (kind == kind_lr)
      begin
        reserv_addr  <= i_riscv_lsu_req.rs1;
        reserv_valid <= 1'b1;
      end
      else if (kind == kind_sc)
      begin
        // any sc drops the reservation, pass or fail
        reserv_addr  <= '0;
        reserv_valid <= 1'b0;
      end
    end
  end

  // rd value of sc, 0 on success and 1 on failure
  always_comb
  begin
    o_riscv_lsu_sc_rdvalue = '0;
    if (kind == kind_sc)
    begin
      o_riscv_lsu_sc_rdvalue[0] = !sc_success;
    end
  end

  // enables and address source
  always_comb
  begin
    case (kind)
      kind_normal_read:
      begin
        o_riscv_lsu_rd_en       = !trap_active;
        o_riscv_lsu_wr_en       = 1'b0;
        o_riscv_lsu_mem_address = i_riscv_lsu_req.alu_result;
      end
      kind_normal_write:
      begin
        o_riscv_lsu_rd_en       = 1'b0;
        o_riscv_lsu_wr_en       = !trap_active;
        o_riscv_lsu_mem_address = i_riscv_lsu_req.alu_result;
      end
      kind_lr:
      begin
        o_riscv_lsu_rd_en       = !trap_active;
        o_riscv_lsu_wr_en       = 1'b0;
        o_riscv_lsu_mem_address = i_riscv_lsu_req.rs1;
      end
      kind_sc:
      begin
        o_riscv_lsu_rd_en       = 1'b0;
        o_riscv_lsu_wr_en       = sc_success; // trap already folded in
        o_riscv_lsu_mem_address = i_riscv_lsu_req.rs1;
      end
      kind_amo:
      begin
        // read half of the amo only
        o_riscv_lsu_rd_en       = !trap_active;
        o_riscv_lsu_wr_en       = 1'b0;
        o_riscv_lsu_mem_address = i_riscv_lsu_req.rs1;
      end
      default:
      begin
        o_riscv_lsu_rd_en       = 1'b0;
        o_riscv_lsu_wr_en       = 1'b0;
        o_riscv_lsu_mem_address = '0;
      end
    endcase
  end

  a_rd_wr_exclusive: assert property (
    @(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
    !(o_riscv_lsu_rd_en && o_riscv_lsu_wr_en))
    else $error("rd_en and wr_en high together");

  // raw sc flag, whatever else is set alongside it
  a_sc_no_read: assert property (
    @(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
    i_riscv_lsu_req.sc |-> !o_riscv_lsu_rd_en)
    else $error("sc raised rd_en");

endmodule

// File: logic/riscv_lsu_pkg.sv
package riscv_lsu_pkg;

  // datapath and address width
  localparam int xlen = 64;

  // data memory depth in double words
  localparam int dmem_words = 512;

  // funct3 size codes for loads and stores
  localparam logic [2:0] size_b  = 3'b000; // signed byte
  localparam logic [2:0] size_h  = 3'b001; // signed half
  localparam logic [2:0] size_w  = 3'b010; // signed word
  localparam logic [2:0] size_d  = 3'b011; // double word
  localparam logic [2:0] size_bu = 3'b100; // unsigned byte
  localparam logic [2:0] size_hu = 3'b101; // unsigned half
  localparam logic [2:0] size_wu = 3'b110; // unsigned word

  // one-hot access kind, bit order {memread, memwrite, lr, sc, amo}
  typedef enum logic [4:0] {
    kind_normal_read  = 5'b10000,
    kind_normal_write = 5'b01000,
    kind_lr           = 5'b00100,
    kind_sc           = 5'b00010,
    kind_amo          = 5'b00001
  } lsu_kind_t;

  // decoded memory request from execute
  typedef struct packed {
    logic            memread;
    logic            memwrite;
    logic            lr;
    logic            sc;
    logic            amo;
    logic [2:0]      size;       // funct3
    logic [xlen-1:0] rs1;        // base for lr, sc and amo
    logic [xlen-1:0] alu_result; // effective address of normal accesses
    logic [xlen-1:0] store_data;
  } lsu_req_t;

  // command presented to the data memory
  typedef struct packed {
    logic            rd_en;
    logic            wr_en;
    logic [xlen-1:0] addr;
    logic [7:0]      byte_en;
    logic [xlen-1:0] wdata;      // already shifted into its byte lanes
  } mem_cmd_t;

endpackage
